//--- all.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_ptr_if.sv
logic/fifo_thresh_regs.sv
logic/fifo_push.sv
logic/fifo_pop.sv
logic/fifo_ctl.sv
testbench/tb_fifo_ctl.sv

//--- logic/fifo_consts.svh
// Depth is fixed at build time by FIFO_ADDR_W; thresholds must not exceed FIFO_DEPTH.
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// Address width of the external RAM.
`define FIFO_ADDR_W 4

// Entries held as a power of two.
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

`define FIFO_PAF_RESET 4 // Free entries below this raise prog_full.
`define FIFO_PAE_RESET 4 // Used entries below this raise prog_empty.

`endif

//--- logic/fifo_ctl.sv
// Single-clock FIFO controller for an external RAM of FIFO_DEPTH entries; no data path.
`include "fifo_consts.svh"

module fifo_ctl (
	input  logic                 rclk,
	input  logic                 rst_n,
	input  logic                 wen,
	input  logic                 ren,
	input  logic                 cfg_we,
	input  logic                 cfg_sel,
	input  logic [`FIFO_ADDR_W:0]   cfg_data,
	output logic [`FIFO_ADDR_W-1:0] waddr,
	output logic [`FIFO_ADDR_W-1:0] raddr,
	output logic                 full,
	output logic                 almost_full,
	output logic                 prog_full,
	output logic                 overflow,
	output logic                 empty,
	output logic                 almost_empty,
	output logic                 prog_empty,
	output logic                 underflow
);
	fifo_pkg::level_t paf_thresh;
	fifo_pkg::level_t pae_thresh;

	fifo_ptr_if ptr_bus ();

	fifo_thresh_regs thresh_inst (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.cfg_we     (cfg_we),
		.cfg_sel    (cfg_sel),
		.cfg_data   (cfg_data),
		.paf_thresh (paf_thresh),
		.pae_thresh (pae_thresh)
	);

	fifo_push push_inst (
		.rclk        (rclk),
		.rst_n       (rst_n),
		.wen         (wen),
		.ptr         (ptr_bus.push),
		.paf_thresh  (paf_thresh),
		.waddr       (waddr),
		.full        (full),
		.almost_full (almost_full),
		.prog_full   (prog_full),
		.overflow    (overflow)
	);

	fifo_pop pop_inst (
		.rclk         (rclk),
		.rst_n        (rst_n),
		.ren          (ren),
		.ptr          (ptr_bus.pop),
		.pae_thresh   (pae_thresh),
		.raddr        (raddr),
		.empty        (empty),
		.almost_empty (almost_empty),
		.prog_empty   (prog_empty),
		.underflow    (underflow)
	);

endmodule

//--- logic/fifo_pkg.sv
// Vector types sized from fifo_consts.svh; the wrap bit makes pointers one bit wider.
`include "fifo_consts.svh"

package fifo_pkg;

	// RAM address taken from the low pointer bits.
	typedef logic [`FIFO_ADDR_W-1:0] addr_t;

	// Pointer with wrap bit.
	typedef logic [`FIFO_ADDR_W:0] ptr_t;

	// Occupancy, free count or threshold up to FIFO_DEPTH.
	typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

//--- logic/fifo_pop.sv
// Single clock only; a pop while empty is dropped and only updates underflow.
`include "fifo_consts.svh"

module fifo_pop (
	input  logic             rclk,
	input  logic             rst_n,
	input  logic             ren,
	fifo_ptr_if.pop          ptr,
	input  fifo_pkg::level_t pae_thresh,
	output fifo_pkg::addr_t  raddr,
	output logic             empty,
	output logic             almost_empty,
	output logic             prog_empty,
	output logic             underflow
);
	logic             pop_ok;
	logic             empty_next;
	logic             almost_empty_next;
	logic             prog_empty_next;
	fifo_pkg::level_t used_next;
	fifo_pkg::level_t used;

	assign pop_ok = ren & ~empty; // Accepted pop.

	assign ptr.rptr_next = ptr.rptr + fifo_pkg::ptr_t'(pop_ok);

	// Occupancy after both sides act this cycle.
	assign used_next = fifo_pkg::level_t'(ptr.wptr_next - ptr.rptr_next);

	// Current occupancy from the registered pointers.
	assign used = fifo_pkg::level_t'(ptr.wptr - ptr.rptr);

	assign empty_next        = (used_next == '0);
	assign almost_empty_next = (used_next == fifo_pkg::level_t'(1));
	assign prog_empty_next   = (used_next < pae_thresh);

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			ptr.rptr <= '0;
		end else begin
			ptr.rptr <= ptr.rptr_next;
		end
	end

	// Empty side starts asserted.
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			empty        <= 1'b1;
			almost_empty <= 1'b0;
			prog_empty   <= 1'b1;
		end else begin
			empty        <= empty_next;
			almost_empty <= almost_empty_next;
			prog_empty   <= prog_empty_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			underflow <= 1'b0;
		end else if (ren) begin
			underflow <= empty; // Set only by a rejected pop.
		end
	end

	assign raddr = ptr.rptr[`FIFO_ADDR_W-1:0];

	// Pointer distance from both sides stays within the RAM.
	occupancy_check: assert property (
		@(posedge rclk) disable iff (!rst_n)
		used <= fifo_pkg::level_t'(`FIFO_DEPTH)
	) else $error("occupancy %0d exceeds FIFO depth", used);

endmodule

//--- logic/fifo_ptr_if.sv
// Single clock domain only; pointers cross between push and pop sides in binary.
interface fifo_ptr_if;

	// Registered pointers.
	fifo_pkg::ptr_t wptr;
	fifo_pkg::ptr_t rptr;

	// Include this cycle's accepted push or pop.
	fifo_pkg::ptr_t wptr_next;
	fifo_pkg::ptr_t rptr_next;

	modport push (
		output wptr,
		output wptr_next,
		input  rptr,
		input  rptr_next
	);

	modport pop (
		output rptr,
		output rptr_next,
		input  wptr,
		input  wptr_next
	);

endinterface

//--- logic/fifo_push.sv
// Single clock only; a push while full is dropped and only updates overflow.
`include "fifo_consts.svh"

module fifo_push (
	input  logic             rclk,
	input  logic             rst_n,
	input  logic             wen,
	fifo_ptr_if.push         ptr,
	input  fifo_pkg::level_t paf_thresh,
	output fifo_pkg::addr_t  waddr,
	output logic             full,
	output logic             almost_full,
	output logic             prog_full,
	output logic             overflow
);
	logic             push_ok;
	logic             full_next;
	logic             almost_full_next;
	logic             prog_full_next;
	fifo_pkg::level_t used_next;
	fifo_pkg::level_t free_next;

	assign push_ok = wen & ~full; // Accepted push.

	assign ptr.wptr_next = ptr.wptr + fifo_pkg::ptr_t'(push_ok);

	// Occupancy after both sides act this cycle.
	assign used_next = fifo_pkg::level_t'(ptr.wptr_next - ptr.rptr_next);
	assign free_next = fifo_pkg::level_t'(`FIFO_DEPTH) - used_next;

	assign full_next        = (free_next == '0);
	assign almost_full_next = (free_next == fifo_pkg::level_t'(1));
	assign prog_full_next   = (free_next < paf_thresh);

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			ptr.wptr <= '0;
		end else begin
			ptr.wptr <= ptr.wptr_next;
		end
	end

	// Flags carry no extra latency over the pointers.
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			full        <= 1'b0;
			almost_full <= 1'b0;
			prog_full   <= 1'b0;
		end else begin
			full        <= full_next;
			almost_full <= almost_full_next;
			prog_full   <= prog_full_next;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (wen) begin
			overflow <= full; // Set only by a rejected push.
		end
	end

	assign waddr = ptr.wptr[`FIFO_ADDR_W-1:0];

	// Back-pressure must hold the write side still.
	full_hold_check: assert property (
		@(posedge rclk) disable iff (!rst_n)
		(full && wen) |=> $stable(ptr.wptr)
	) else $error("wptr moved on a push while full");

endmodule

//--- logic/fifo_thresh_regs.sv
// Thresholds take effect from the edge after the write; values above FIFO_DEPTH are illegal.
`include "fifo_consts.svh"

module fifo_thresh_regs (
	input  logic             rclk,
	input  logic             rst_n,
	input  logic             cfg_we,
	input  logic             cfg_sel,
	input  fifo_pkg::level_t cfg_data,
	output fifo_pkg::level_t paf_thresh,
	output fifo_pkg::level_t pae_thresh
);
	logic paf_we;
	logic pae_we;

	// cfg_sel 0 is the full side, 1 the empty side.
	assign paf_we = cfg_we & ~cfg_sel;
	assign pae_we = cfg_we & cfg_sel;

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			paf_thresh <= fifo_pkg::level_t'(`FIFO_PAF_RESET);
		end else if (paf_we) begin
			paf_thresh <= cfg_data;
		end
	end

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			pae_thresh <= fifo_pkg::level_t'(`FIFO_PAE_RESET);
		end else if (pae_we) begin
			pae_thresh <= cfg_data;
		end
	end

	// A threshold above the depth would pin a prog flag forever.
	cfg_range_check: assert property (
		@(posedge rclk) disable iff (!rst_n)
		cfg_we |-> (cfg_data <= fifo_pkg::level_t'(`FIFO_DEPTH))
	) else $error("cfg_data %0d exceeds FIFO depth", cfg_data);

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fifo_ctl -f all.f -o sim_tb_fifo_ctl \
	&& ./obj_dir/sim_tb_fifo_ctl | tee /dev/stderr | grep -q "TB PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- testbench/tb_fifo_ctl.sv
// Cycle model of fifo_ctl at FIFO_ADDR_W from the constants header; random phase has a fixed seed.
`include "fifo_consts.svh"

module tb_fifo_ctl;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD      = 100;
	localparam int RANDOM_CYCLES   = 300;
	localparam int STIM_CYCLES     = 400; // Reset, directed phases and the random mix.
	localparam int WATCHDOG_CYCLES = STIM_CYCLES * 3 / 2;

	logic rclk;
	logic rst_n;
	logic wen;
	logic ren;
	logic cfg_we;
	logic cfg_sel;
	logic [`FIFO_ADDR_W:0] cfg_data;
	logic [`FIFO_ADDR_W-1:0] waddr;
	logic [`FIFO_ADDR_W-1:0] raddr;
	logic full, almost_full, prog_full, overflow;
	logic empty, almost_empty, prog_empty, underflow;

	// Model occupancy, both RAM addresses and the two thresholds.
	fifo_pkg::level_t m_count;
	fifo_pkg::level_t m_count_next;
	fifo_pkg::addr_t  m_waddr;
	fifo_pkg::addr_t  m_raddr;
	fifo_pkg::level_t m_paf;
	fifo_pkg::level_t m_pae;
	logic             m_push;
	logic             m_pop;
	logic exp_full, exp_almost_full, exp_prog_full, exp_overflow;
	logic exp_empty, exp_almost_empty, exp_prog_empty, exp_underflow;

	string       test_name;
	logic [31:0] rng_state;

	fifo_ctl fifo_ctl_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string sig, input int expected, input int actual);
		$display("[ERROR] %s: %s expected %0d, actual %0d", test_name, sig, expected, actual);
		abort_run();
	endtask

	task automatic report_failure(input string what);
		$display("%s (test %s)", what, test_name);
		abort_run();
	endtask

	initial begin
		rclk = 1'b0;
		forever #(CLK_PERIOD / 2) rclk = ~rclk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired before the stimulus finished");
	end

	// Acceptance follows the flags, not the request.
	assign m_push       = wen && (m_count != fifo_pkg::level_t'(`FIFO_DEPTH));
	assign m_pop        = ren && (m_count != '0);
	assign m_count_next = m_count + fifo_pkg::level_t'(m_push) - fifo_pkg::level_t'(m_pop);

	always @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			m_count          <= '0;
			m_waddr          <= '0;
			m_raddr          <= '0;
			m_paf            <= fifo_pkg::level_t'(`FIFO_PAF_RESET);
			m_pae            <= fifo_pkg::level_t'(`FIFO_PAE_RESET);
			exp_full         <= 1'b0;
			exp_almost_full  <= 1'b0;
			exp_prog_full    <= 1'b0;
			exp_overflow     <= 1'b0;
			exp_empty        <= 1'b1;
			exp_almost_empty <= 1'b0;
			exp_prog_empty   <= 1'b1;
			exp_underflow    <= 1'b0;
		end else begin
			m_count          <= m_count_next;
			m_waddr          <= m_waddr + fifo_pkg::addr_t'(m_push);
			m_raddr          <= m_raddr + fifo_pkg::addr_t'(m_pop);
			exp_full         <= (m_count_next == fifo_pkg::level_t'(`FIFO_DEPTH));
			exp_almost_full  <= (m_count_next == fifo_pkg::level_t'(`FIFO_DEPTH - 1));
			exp_prog_full    <= (fifo_pkg::level_t'(`FIFO_DEPTH) - m_count_next) < m_paf;
			exp_empty        <= (m_count_next == '0);
			exp_almost_empty <= (m_count_next == fifo_pkg::level_t'(1));
			exp_prog_empty   <= (m_count_next < m_pae); // Old threshold until the next edge.
			if (wen) exp_overflow <= !m_push;
			if (ren) exp_underflow <= !m_pop;
			if (cfg_we && !cfg_sel) m_paf <= cfg_data;
			if (cfg_we && cfg_sel) m_pae <= cfg_data;
		end
	end

	reset_state_check: assert property (@(posedge rclk) $rose(rst_n) |->
		(waddr == '0 && raddr == '0 && empty && prog_empty && !full && !almost_full
		&& !prog_full && !overflow && !almost_empty && !underflow))
		else report_failure("Outputs were not at their reset values when reset was released");

	waddr_check: assert property (@(posedge rclk) disable iff (!rst_n) waddr == m_waddr)
		else report_mismatch("waddr", int'($sampled(m_waddr)), int'($sampled(waddr)));
	raddr_check: assert property (@(posedge rclk) disable iff (!rst_n) raddr == m_raddr)
		else report_mismatch("raddr", int'($sampled(m_raddr)), int'($sampled(raddr)));
	full_check: assert property (@(posedge rclk) disable iff (!rst_n) full == exp_full)
		else report_mismatch("full", int'($sampled(exp_full)), int'($sampled(full)));
	afull_check: assert property (@(posedge rclk) disable iff (!rst_n) almost_full == exp_almost_full)
		else report_mismatch("almost_full", int'($sampled(exp_almost_full)),
			int'($sampled(almost_full)));
	pfull_check: assert property (@(posedge rclk) disable iff (!rst_n) prog_full == exp_prog_full)
		else report_mismatch("prog_full", int'($sampled(exp_prog_full)), int'($sampled(prog_full)));
	ovf_check: assert property (@(posedge rclk) disable iff (!rst_n) overflow == exp_overflow)
		else report_mismatch("overflow", int'($sampled(exp_overflow)), int'($sampled(overflow)));
	empty_check: assert property (@(posedge rclk) disable iff (!rst_n) empty == exp_empty)
		else report_mismatch("empty", int'($sampled(exp_empty)), int'($sampled(empty)));
	aempty_check: assert property (@(posedge rclk) disable iff (!rst_n)
		almost_empty == exp_almost_empty)
		else report_mismatch("almost_empty", int'($sampled(exp_almost_empty)),
			int'($sampled(almost_empty)));
	pempty_check: assert property (@(posedge rclk) disable iff (!rst_n) prog_empty == exp_prog_empty)
		else report_mismatch("prog_empty", int'($sampled(exp_prog_empty)),
			int'($sampled(prog_empty)));
	udf_check: assert property (@(posedge rclk) disable iff (!rst_n) underflow == exp_underflow)
		else report_mismatch("underflow", int'($sampled(exp_underflow)), int'($sampled(underflow)));

	task automatic drive(input logic w, input logic r, input int cycles);
		repeat (cycles) begin
			@(posedge rclk);
			wen <= w;
			ren <= r;
		end
	endtask

	task automatic write_threshold(input logic sel, input fifo_pkg::level_t value);
		@(posedge rclk);
		cfg_we   <= 1'b1;
		cfg_sel  <= sel;
		cfg_data <= value;
		@(posedge rclk);
		cfg_we   <= 1'b0;
	endtask

	// Polls between edges, where flags are settled.
	task automatic await_flag(input logic want_full);
		int n;
		n = 0;
		@(negedge rclk);
		while ((want_full ? full : empty) !== 1'b1) begin
			if (n == 4) begin
				report_failure(want_full ? "Full never rose" : "Empty never rose");
			end else begin
				n++;
				@(negedge rclk);
			end
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		wen       = 1'b0;
		ren       = 1'b0;
		cfg_we    = 1'b0;
		cfg_sel   = 1'b0;
		cfg_data  = '0;
		rng_state = 32'd51420;
		test_name = "reset";
		repeat (3) @(posedge rclk);
		rst_n <= 1'b1;
		drive(1'b0, 1'b0, 1);
		test_name = "fill";
		drive(1'b1, 1'b0, `FIFO_DEPTH);
		drive(1'b0, 1'b0, 1);
		await_flag(1'b1);
		test_name = "overflow";
		drive(1'b1, 1'b0, 2); // Both rejected.
		drive(1'b0, 1'b1, 1);
		drive(1'b1, 1'b0, 1);
		test_name = "drain";
		drive(1'b0, 1'b1, `FIFO_DEPTH);
		drive(1'b0, 1'b0, 1);
		await_flag(1'b0);
		test_name = "underflow";
		drive(1'b0, 1'b1, 2);
		drive(1'b0, 1'b0, 1);
		test_name = "thresholds";
		write_threshold(1'b0, 5'd10);
		write_threshold(1'b1, 5'd6);
		drive(1'b1, 1'b0, `FIFO_DEPTH);
		drive(1'b0, 1'b1, `FIFO_DEPTH);
		test_name = "random";
		repeat (RANDOM_CYCLES) begin
			rng_state = xorshift32(rng_state);
			drive(rng_state[0], rng_state[7], 1);
		end
		drive(1'b0, 1'b0, 2);
		$display("TB PASSED");
		$finish;
	end

endmodule
